// File: src/mips_pkg.sv
`default_nettype none

package mips_pkg;

	// Primary opcode field, instr[31:26]
	typedef enum logic [5:0] {
		op_rtype = 6'h00,
		op_j     = 6'h02,
		op_beq   = 6'h04,
		op_addiu = 6'h09,
		op_lw    = 6'h23,
		op_sw    = 6'h2b
	} opcode_t;

	// R-type function field, instr[5:0]
	typedef enum logic [5:0] {
		fn_addu = 6'h21,
		fn_subu = 6'h23,
		fn_and  = 6'h24,
		fn_or   = 6'h25,
		fn_slt  = 6'h2a
	} funct_t;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_slt
	} alu_op_t;

	// Next PC choice
	typedef enum logic [1:0] {
		pc_seq,
		pc_branch,
		pc_jump
	} pc_src_t;

	typedef enum logic [2:0] {
		st_fetch,
		st_decode,
		st_execute,
		st_memory,
		st_writeback
	} cpu_state_t;

endpackage

`default_nettype wire

// File: src/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
	input wire clk,
	input wire mips_pkg::alu_op_t op,
	input wire [31:0] a,
	input wire [31:0] b,
	output logic [31:0] result,
	output logic zero
);

logic [31:0] value;
logic less;

// Signed compare for slt
assign less = $signed(a) < $signed(b);

always_comb begin
	case (op)
		mips_pkg::alu_sub: value = a - b;
		mips_pkg::alu_and: value = a & b;
		mips_pkg::alu_or: value = a | b;
		mips_pkg::alu_slt: value = {31'h0, less};
		default: value = a + b;
	endcase
end

// Used by beq in the execute cycle itself
assign zero = (value == 32'h0);

always_ff @(posedge clk) begin
	result <= value;
end

endmodule

`default_nettype wire

// File: src/regfile.sv
`timescale 1ns/100ps
`default_nettype none

module regfile (
	input wire clk,
	input wire cop_reset,
	input wire [4:0] rs,
	input wire [4:0] rt,
	input wire [4:0] rd,
	input wire dst_rd,
	input wire we,
	input wire [31:0] wdata,
	output logic [31:0] rs_data,
	output logic [31:0] rt_data
);

logic [31:0] regs [32];
logic [4:0] dst;

assign dst = dst_rd ? rd : rt;

// Register 0 is never written, so it stays zero
always_ff @(posedge clk) begin
	if (cop_reset) begin
		for (int i = 0; i < 32; i++)
			regs[i] <= 32'h0;
	end else if (we && (dst != 5'd0)) begin
		regs[dst] <= wdata;
	end
end

// Registered reads, stable from execute on
always_ff @(posedge clk) begin
	rs_data <= regs[rs];
	rt_data <= regs[rt];
end

endmodule

`default_nettype wire

// File: src/fetch_unit.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_unit #(
	parameter logic [31:0] reset_pc = 32'h0000_0000
) (
	input wire clk,
	input wire cop_reset,
	input wire ir_load,
	input wire pc_load,
	input wire mips_pkg::pc_src_t pc_src,
	input wire [31:0] instr,
	output logic [31:0] pc,
	output mips_pkg::opcode_t opcode,
	output mips_pkg::funct_t funct,
	output logic [4:0] rs,
	output logic [4:0] rt,
	output logic [4:0] rd,
	output logic [31:0] imm
);

logic [31:0] ir;
logic [31:0] pc_inc;
logic [31:0] branch_target;
logic [31:0] jump_target;
logic [31:0] pc_next;

assign opcode = mips_pkg::opcode_t'(ir[31:26]);
assign funct = mips_pkg::funct_t'(ir[5:0]);
assign rs = ir[25:21];
assign rt = ir[20:16];
assign rd = ir[15:11];
assign imm = {{16{ir[15]}}, ir[15:0]};

// pc already points past the instruction once the IR is loaded
assign pc_inc = pc + 32'd4;
assign branch_target = pc + {imm[29:0], 2'b00};
assign jump_target = {pc[31:28], ir[25:0], 2'b00};

always_comb begin
	case (pc_src)
		mips_pkg::pc_branch: pc_next = branch_target;
		mips_pkg::pc_jump: pc_next = jump_target;
		default: pc_next = pc_inc;
	endcase
end

always_ff @(posedge clk) begin
	if (cop_reset)
		pc <= reset_pc;
	else if (pc_load)
		pc <= pc_next;
end

always_ff @(posedge clk) begin
	if (ir_load)
		ir <= instr;
end

endmodule

`default_nettype wire

// File: src/mem_port.sv
`timescale 1ns/100ps
`default_nettype none

module mem_port (
	input wire clk,
	input wire cop_reset,
	input wire bus_start,
	input wire bus_write,
	input wire [31:0] bus_addr,
	input wire [31:0] bus_wdata,
	output logic bus_done,
	output logic [31:0] bus_rdata,
	// External memory
	output logic mem_enable,
	output logic mem_rw,
	input wire mem_ack,
	output logic [31:0] mem_addr,
	input wire [31:0] mem_data_out,
	output logic [31:0] mem_data_in
);

typedef enum logic {
	bus_idle,
	bus_wait
} bus_state_t;

bus_state_t state;

assign mem_enable = (state == bus_wait);

always_ff @(posedge clk) begin
	if (cop_reset) begin
		state <= bus_idle;
		bus_done <= 1'b0;
	end else begin
		bus_done <= 1'b0;
		case (state)
			bus_idle: begin
				if (bus_start)
					state <= bus_wait;
			end
			default: begin
				if (mem_ack) begin
					state <= bus_idle;
					bus_done <= 1'b1;
				end
			end
		endcase
	end
end

// Request held unchanged until acknowledge
always_ff @(posedge clk) begin
	if ((state == bus_idle) && bus_start) begin
		mem_addr <= bus_addr;
		mem_rw <= !bus_write;
		mem_data_in <= bus_wdata;
	end
	if ((state == bus_wait) && mem_ack)
		bus_rdata <= mem_data_out;
end

endmodule

`default_nettype wire

// File: src/control.sv
`timescale 1ns/100ps
`default_nettype none

module control (
	input wire clk,
	input wire cop_reset,
	input wire mips_pkg::opcode_t opcode,
	input wire mips_pkg::funct_t funct,
	input wire alu_zero,
	input wire bus_done,
	output logic bus_start,
	output logic bus_write,
	output logic addr_from_alu,
	output logic ir_load,
	output logic pc_load,
	output mips_pkg::pc_src_t pc_src,
	output logic reg_we,
	output logic reg_dst_rd,
	output logic mem_to_reg,
	output logic alu_src_imm,
	output mips_pkg::alu_op_t alu_op
);

mips_pkg::cpu_state_t state;
mips_pkg::cpu_state_t state_next;
logic issued;
logic bus_phase;

//////////////////////////////////////////////////////////////////////
// State register

// One request per bus state, cleared again on completion
assign bus_phase = (state == mips_pkg::st_fetch) || (state == mips_pkg::st_memory);
assign bus_start = bus_phase && !issued && !cop_reset;

always_ff @(posedge clk) begin
	if (cop_reset) begin
		state <= mips_pkg::st_fetch;
		issued <= 1'b0;
	end else begin
		state <= state_next;
		if (bus_done)
			issued <= 1'b0;
		else if (bus_start)
			issued <= 1'b1;
	end
end

always_comb begin
	state_next = state;
	case (state)
		mips_pkg::st_fetch: begin
			if (bus_done)
				state_next = mips_pkg::st_decode;
		end
		mips_pkg::st_decode: state_next = mips_pkg::st_execute;
		mips_pkg::st_execute: begin
			case (opcode)
				mips_pkg::op_lw, mips_pkg::op_sw: state_next = mips_pkg::st_memory;
				mips_pkg::op_rtype, mips_pkg::op_addiu: state_next = mips_pkg::st_writeback;
				// beq, j and unknown opcodes
				default: state_next = mips_pkg::st_fetch;
			endcase
		end
		mips_pkg::st_memory: begin
			if (bus_done)
				state_next = (opcode == mips_pkg::op_lw) ? mips_pkg::st_writeback
					: mips_pkg::st_fetch;
		end
		default: state_next = mips_pkg::st_fetch;
	endcase
end

//////////////////////////////////////////////////////////////////////
// Strobes

assign ir_load = (state == mips_pkg::st_fetch) && bus_done;
assign addr_from_alu = (state == mips_pkg::st_memory);
assign bus_write = (state == mips_pkg::st_memory) && (opcode == mips_pkg::op_sw);
assign reg_we = (state == mips_pkg::st_writeback);
assign reg_dst_rd = (opcode == mips_pkg::op_rtype);
assign mem_to_reg = (opcode == mips_pkg::op_lw);
assign alu_src_imm = (opcode != mips_pkg::op_rtype) && (opcode != mips_pkg::op_beq);

always_comb begin
	pc_load = 1'b0;
	pc_src = mips_pkg::pc_seq;
	if (state == mips_pkg::st_fetch) begin
		pc_load = bus_done;
	end else if (state == mips_pkg::st_execute) begin
		if (opcode == mips_pkg::op_beq) begin
			pc_load = alu_zero;
			pc_src = mips_pkg::pc_branch;
		end else if (opcode == mips_pkg::op_j) begin
			pc_load = 1'b1;
			pc_src = mips_pkg::pc_jump;
		end
	end
end

// ALU operation held for the whole instruction
always_comb begin
	alu_op = mips_pkg::alu_add;
	if (opcode == mips_pkg::op_beq) begin
		alu_op = mips_pkg::alu_sub;
	end else if (opcode == mips_pkg::op_rtype) begin
		case (funct)
			mips_pkg::fn_subu: alu_op = mips_pkg::alu_sub;
			mips_pkg::fn_and: alu_op = mips_pkg::alu_and;
			mips_pkg::fn_or: alu_op = mips_pkg::alu_or;
			mips_pkg::fn_slt: alu_op = mips_pkg::alu_slt;
			default: alu_op = mips_pkg::alu_add;
		endcase
	end
end

endmodule

`default_nettype wire

// File: src/cpu.sv
`timescale 1ns/100ps
`default_nettype none

module cpu #(
	parameter logic [31:0] reset_pc = 32'h0000_0000
) (
	input wire clk,
	input wire cop_reset,
	// Memory ports
	output logic mem_enable,
	output logic mem_rw,
	input wire mem_ack,
	output logic [31:0] mem_addr,
	input wire [31:0] mem_data_out,
	output logic [31:0] mem_data_in
);

//////////////////////////////////////////////////////////////////////
// Control strobes

mips_pkg::opcode_t opcode;
mips_pkg::funct_t funct;
mips_pkg::pc_src_t pc_src;
mips_pkg::alu_op_t alu_op;
logic alu_zero;
logic bus_start;
logic bus_write;
logic bus_done;
logic addr_from_alu;
logic ir_load;
logic pc_load;
logic reg_we;
logic reg_dst_rd;
logic mem_to_reg;
logic alu_src_imm;

control i_control (
	.clk(clk),
	.cop_reset(cop_reset),
	.opcode(opcode),
	.funct(funct),
	.alu_zero(alu_zero),
	.bus_done(bus_done),
	.bus_start(bus_start),
	.bus_write(bus_write),
	.addr_from_alu(addr_from_alu),
	.ir_load(ir_load),
	.pc_load(pc_load),
	.pc_src(pc_src),
	.reg_we(reg_we),
	.reg_dst_rd(reg_dst_rd),
	.mem_to_reg(mem_to_reg),
	.alu_src_imm(alu_src_imm),
	.alu_op(alu_op)
);

//////////////////////////////////////////////////////////////////////
// Datapath

logic [31:0] pc;
logic [31:0] imm;
logic [4:0] rs;
logic [4:0] rt;
logic [4:0] rd;
logic [31:0] rs_data;
logic [31:0] rt_data;
logic [31:0] alu_b;
logic [31:0] alu_result;
logic [31:0] reg_wdata;
logic [31:0] bus_addr;
logic [31:0] bus_rdata;

// Operand, write-back and address selects
assign alu_b = alu_src_imm ? imm : rt_data;
assign reg_wdata = mem_to_reg ? bus_rdata : alu_result;
assign bus_addr = addr_from_alu ? alu_result : pc;

fetch_unit #(
	.reset_pc(reset_pc)
) i_fetch_unit (
	.clk(clk),
	.cop_reset(cop_reset),
	.ir_load(ir_load),
	.pc_load(pc_load),
	.pc_src(pc_src),
	.instr(bus_rdata),
	.pc(pc),
	.opcode(opcode),
	.funct(funct),
	.rs(rs),
	.rt(rt),
	.rd(rd),
	.imm(imm)
);

regfile i_regfile (
	.clk(clk),
	.cop_reset(cop_reset),
	.rs(rs),
	.rt(rt),
	.rd(rd),
	.dst_rd(reg_dst_rd),
	.we(reg_we),
	.wdata(reg_wdata),
	.rs_data(rs_data),
	.rt_data(rt_data)
);

alu i_alu (
	.clk(clk),
	.op(alu_op),
	.a(rs_data),
	.b(alu_b),
	.result(alu_result),
	.zero(alu_zero)
);

//////////////////////////////////////////////////////////////////////
// Memory bus

mem_port i_mem_port (
	.clk(clk),
	.cop_reset(cop_reset),
	.bus_start(bus_start),
	.bus_write(bus_write),
	.bus_addr(bus_addr),
	.bus_wdata(rt_data),
	.bus_done(bus_done),
	.bus_rdata(bus_rdata),
	.mem_enable(mem_enable),
	.mem_rw(mem_rw),
	.mem_ack(mem_ack),
	.mem_addr(mem_addr),
	.mem_data_out(mem_data_out),
	.mem_data_in(mem_data_in)
);

endmodule

`default_nettype wire

// File: test/clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module clock_gen (
	output logic clk,
	output logic cop_reset
);

initial begin
	clk = 1'b0;
	forever #2 clk = ~clk;
end

// Released just after the tenth rising edge
initial begin
	cop_reset = 1'b1;
	repeat (10) @(posedge clk);
	#0.5;
	cop_reset = 1'b0;
end

endmodule

`default_nettype wire

// File: test/cpu_sva.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_sva (
	input wire clk,
	input wire cop_reset,
	input wire mem_enable,
	input wire mem_rw,
	input wire mem_ack,
	input wire [31:0] mem_addr,
	input wire [31:0] mem_data_in,
	input wire mips_pkg::cpu_state_t state
);

// Bus idle and FSM in fetch right after a reset cycle
a_reset_idle: assert property (@(posedge clk)
	cop_reset |=> !mem_enable && (state == mips_pkg::st_fetch))
	else $error("memory request or wrong FSM state after reset");

a_request_held: assert property (@(posedge clk) disable iff (cop_reset)
	mem_enable && !mem_ack |=> mem_enable && $stable(mem_addr) && $stable(mem_rw)
		&& $stable(mem_data_in))
	else $error("memory request changed before acknowledge");

a_release_after_ack: assert property (@(posedge clk) disable iff (cop_reset)
	mem_enable && mem_ack |=> !mem_enable)
	else $error("mem_enable still high after acknowledge");

// Only the two bus states talk to memory
a_bus_state: assert property (@(posedge clk) disable iff (cop_reset)
	mem_enable |-> (state == mips_pkg::st_fetch) || (state == mips_pkg::st_memory))
	else $error("memory request outside fetch and memory states");

endmodule

bind cpu cpu_sva i_cpu_sva (
	.clk(clk),
	.cop_reset(cop_reset),
	.mem_enable(mem_enable),
	.mem_rw(mem_rw),
	.mem_ack(mem_ack),
	.mem_addr(mem_addr),
	.mem_data_in(mem_data_in),
	.state(i_control.state)
);

`default_nettype wire

// File: test/tb_cpu.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cpu;

localparam logic [31:0] reset_pc = 32'h0000_0040;
localparam logic [31:0] data_base = 32'h0000_0200;
localparam int mem_words = 256;

logic clk;
logic cop_reset;
logic mem_enable;
logic mem_rw;
logic mem_ack;
logic [31:0] mem_addr;
logic [31:0] mem_data_out;
logic [31:0] mem_data_in;

logic [31:0] mem [mem_words];
logic [31:0] ref_mem [mem_words];
logic [31:0] ref_regs [32];
logic [31:0] data_table [4];
logic [31:0] prog_word [$];
string prog_note [$];
logic [31:0] exp_read_addr [$];
string exp_read_note [$];
logic [31:0] exp_store_addr [$];
logic [31:0] exp_store_data [$];
string exp_store_note [$];
logic [31:0] final_pc;
logic [31:0] lfsr_state;
int exp_store_total;
int writes_done;
int checks;
int value_errors;
int other_errors;

clock_gen i_clock_gen (
	.clk(clk),
	.cop_reset(cop_reset)
);

cpu #(
	.reset_pc(reset_pc)
) i_dut (
	.clk(clk),
	.cop_reset(cop_reset),
	.mem_enable(mem_enable),
	.mem_rw(mem_rw),
	.mem_ack(mem_ack),
	.mem_addr(mem_addr),
	.mem_data_out(mem_data_out),
	.mem_data_in(mem_data_in)
);

//////////////////////////////////////////////////////////////////////
// Random numbers and encoders

// Taps 32, 22, 2, 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] value;
	value = 32'h0;
	for (int i = 0; i < n; i++) begin
		lfsr_state = lfsr_step(lfsr_state);
		value = {value[30:0], lfsr_state[0]};
	end
	return value;
endfunction

function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
	input logic [4:0] rd, input mips_pkg::funct_t fn);
	return {mips_pkg::op_rtype, rs, rt, rd, 5'd0, fn};
endfunction

function automatic logic [31:0] enc_i(input mips_pkg::opcode_t op, input logic [4:0] rs,
	input logic [4:0] rt, input logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

function automatic logic [31:0] enc_j(input logic [31:0] target);
	return {mips_pkg::op_j, target[27:2]};
endfunction

function automatic logic [31:0] addr_of(input int i);
	return reset_pc + 32'(i * 4);
endfunction

function automatic int word_index(input logic [31:0] addr);
	return int'(addr[9:2]);
endfunction

//////////////////////////////////////////////////////////////////////
// Program table

task automatic add_instr(input logic [31:0] word, input string note);
	prog_word.push_back(word);
	prog_note.push_back(note);
endtask

task automatic build_program();
	add_instr(enc_i(mips_pkg::op_addiu, 0, 1, 16'h0200), "r1 = data base");
	add_instr(enc_i(mips_pkg::op_lw, 1, 2, 16'h0000), "r2 = data 0");
	add_instr(enc_i(mips_pkg::op_lw, 1, 3, 16'h0004), "r3 = data 1");
	add_instr(enc_i(mips_pkg::op_lw, 1, 4, 16'h0008), "r4 = data 2, negative");
	add_instr(enc_i(mips_pkg::op_lw, 1, 5, 16'h000c), "r5 = data 3, negative");
	add_instr(enc_r(2, 3, 6, mips_pkg::fn_addu), "r6 = r2 + r3");
	add_instr(enc_i(mips_pkg::op_sw, 1, 6, 16'h0020), "store r6");
	add_instr(enc_r(2, 3, 7, mips_pkg::fn_subu), "r7 = r2 - r3");
	add_instr(enc_i(mips_pkg::op_sw, 1, 7, 16'h0024), "store r7");
	add_instr(enc_r(2, 4, 8, mips_pkg::fn_and), "r8 = r2 & r4");
	add_instr(enc_i(mips_pkg::op_sw, 1, 8, 16'h0028), "store r8");
	add_instr(enc_r(3, 5, 9, mips_pkg::fn_or), "r9 = r3 | r5");
	add_instr(enc_i(mips_pkg::op_sw, 1, 9, 16'h002c), "store r9");
	add_instr(enc_r(4, 5, 10, mips_pkg::fn_slt), "r10 = r4 < r5, both negative");
	add_instr(enc_i(mips_pkg::op_sw, 1, 10, 16'h0030), "store r10");
	add_instr(enc_r(5, 2, 11, mips_pkg::fn_slt), "r11 = r5 < r2");
	add_instr(enc_i(mips_pkg::op_sw, 1, 11, 16'h0034), "store r11");
	add_instr(enc_i(mips_pkg::op_addiu, 2, 12, 16'hfffb), "r12 = r2 - 5");
	add_instr(enc_i(mips_pkg::op_sw, 1, 12, 16'h0038), "store r12");
	add_instr(enc_r(2, 3, 0, mips_pkg::fn_addu), "write to r0 ignored");
	add_instr(enc_i(mips_pkg::op_sw, 1, 0, 16'h003c), "store r0, zero");
	add_instr(enc_i(mips_pkg::op_beq, 2, 2, 16'h0001), "beq taken, skip one");
	add_instr(enc_i(mips_pkg::op_sw, 1, 2, 16'h0040), "skipped store");
	add_instr(enc_i(mips_pkg::op_beq, 2, 3, 16'h0001), "beq not taken");
	add_instr(enc_i(mips_pkg::op_sw, 1, 3, 16'h0044), "store r3");
	add_instr(enc_i(mips_pkg::op_lw, 1, 13, 16'h0020), "r13 = stored sum");
	add_instr(enc_j(addr_of(28)), "jump over one");
	add_instr(enc_i(mips_pkg::op_sw, 1, 2, 16'h004c), "skipped store");
	add_instr(enc_i(mips_pkg::op_sw, 1, 13, 16'h0048), "store r13");
	add_instr(enc_j(addr_of(29)), "idle loop");
endtask

task automatic build_data();
	for (int i = 0; i < 4; i++)
		data_table[i] = rand_bits(32);
	// Sign bits fixed for the slt cases
	data_table[0][31] = 1'b0;
	data_table[2][31] = 1'b1;
	data_table[3][31] = 1'b1;
	if (data_table[1] == data_table[0])
		data_table[1][0] = ~data_table[1][0];
endtask

task automatic load_memory();
	for (int i = 0; i < mem_words; i++)
		mem[i] = 32'h5a5a_0000 ^ (32'(i) << 2);
	for (int i = 0; i < prog_word.size(); i++)
		mem[word_index(addr_of(i))] = prog_word[i];
	for (int i = 0; i < 4; i++)
		mem[word_index(data_base + 32'(i * 4))] = data_table[i];
	for (int i = 0; i < mem_words; i++)
		ref_mem[i] = mem[i];
endtask

//////////////////////////////////////////////////////////////////////
// Reference model, one instruction per step

task automatic run_reference();
	logic [31:0] pc;
	logic [31:0] instr;
	logic [31:0] next_pc;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] imm;
	logic [31:0] addr;
	logic [31:0] result;
	mips_pkg::opcode_t op;
	mips_pkg::funct_t fn;
	string note;
	int idx;
	int steps;
	logic done;
	pc = reset_pc;
	done = 1'b0;
	steps = 0;
	for (int r = 0; r < 32; r++)
		ref_regs[r] = 32'h0;
	while (!done && (steps < 200)) begin
		idx = int'((pc - reset_pc) >> 2);
		note = (idx < prog_note.size()) ? prog_note[idx] : "outside program";
		instr = ref_mem[word_index(pc)];
		exp_read_addr.push_back(pc);
		exp_read_note.push_back($sformatf("fetch at %h (%s)", pc, note));
		op = mips_pkg::opcode_t'(instr[31:26]);
		fn = mips_pkg::funct_t'(instr[5:0]);
		a = ref_regs[instr[25:21]];
		b = ref_regs[instr[20:16]];
		imm = {{16{instr[15]}}, instr[15:0]};
		addr = a + imm;
		next_pc = pc + 32'd4;
		case (op)
			mips_pkg::op_rtype: begin
				case (fn)
					mips_pkg::fn_subu: result = a - b;
					mips_pkg::fn_and: result = a & b;
					mips_pkg::fn_or: result = a | b;
					mips_pkg::fn_slt: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default: result = a + b;
				endcase
				if (instr[15:11] != 5'd0)
					ref_regs[instr[15:11]] = result;
			end
			mips_pkg::op_addiu: begin
				if (instr[20:16] != 5'd0)
					ref_regs[instr[20:16]] = addr;
			end
			mips_pkg::op_lw: begin
				exp_read_addr.push_back(addr);
				exp_read_note.push_back($sformatf("load for %s", note));
				if (instr[20:16] != 5'd0)
					ref_regs[instr[20:16]] = ref_mem[word_index(addr)];
			end
			mips_pkg::op_sw: begin
				exp_store_addr.push_back(addr);
				exp_store_data.push_back(b);
				exp_store_note.push_back(note);
				ref_mem[word_index(addr)] = b;
			end
			mips_pkg::op_beq: begin
				if (a == b)
					next_pc = next_pc + {imm[29:0], 2'b00};
			end
			mips_pkg::op_j: begin
				next_pc = {next_pc[31:28], instr[25:0], 2'b00};
				if (next_pc == pc) begin
					done = 1'b1;
					final_pc = pc;
				end
			end
			default: begin
				$display("Reference model found an unknown opcode at %h", pc);
				other_errors++;
			end
		endcase
		steps++;
		pc = next_pc;
	end
	if (!done) begin
		$display("Reference model did not reach the idle loop");
		other_errors++;
	end
	exp_store_total = exp_store_addr.size();
endtask

//////////////////////////////////////////////////////////////////////
// Checks

task automatic check_addr(input logic [31:0] got, input logic [31:0] exp, input string what);
	checks++;
	if (got !== exp) begin
		value_errors++;
		$display("Error at %0t: %s address is %h, expected %h", $time, what, got, exp);
	end
endtask

task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
	checks++;
	if (got !== exp) begin
		value_errors++;
		$display("Error at %0t: %s data is %h, expected %h", $time, what, got, exp);
	end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
	checks++;
	if (got !== exp) begin
		value_errors++;
		$display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
	end
endtask

//////////////////////////////////////////////////////////////////////
// Memory model

task automatic check_request();
	string note;
	if (mem_rw) begin
		if (exp_read_addr.size() > 0) begin
			note = exp_read_note.pop_front();
			check_addr(mem_addr, exp_read_addr.pop_front(), note);
		end else begin
			check_addr(mem_addr, final_pc, "idle loop fetch");
		end
	end else if (exp_store_addr.size() > 0) begin
		note = exp_store_note.pop_front();
		check_addr(mem_addr, exp_store_addr.pop_front(), note);
		check_word(mem_data_in, exp_store_data.pop_front(), note);
	end else begin
		$display("Unexpected write to %h at %0t with no store left in the program",
			mem_addr, $time);
		other_errors++;
	end
endtask

task automatic complete_transfer();
	int idx;
	idx = word_index(mem_addr);
	if (mem_rw) begin
		mem_data_out = mem[idx];
	end else begin
		mem[idx] = mem_data_in;
		writes_done++;
	end
	mem_ack = 1'b1;
endtask

// Ack after 0 to 3 cycles, drop it once taken
initial begin : memory_model
	int wait_left;
	logic busy;
	busy = 1'b0;
	wait_left = 0;
	forever begin
		@(posedge clk);
		#0.5;
		if (cop_reset || mem_ack) begin
			mem_ack = 1'b0;
			busy = 1'b0;
		end else if (mem_enable) begin
			if (!busy) begin
				busy = 1'b1;
				wait_left = int'(rand_bits(2));
				check_request();
			end
			if (wait_left == 0)
				complete_transfer();
			else
				wait_left--;
		end
	end
end

//////////////////////////////////////////////////////////////////////
// Main sequence

initial begin : main
	int cycles;
	mem_ack = 1'b0;
	mem_data_out = 32'h0;
	lfsr_state = 32'd83216;
	final_pc = 32'h0;
	writes_done = 0;
	checks = 0;
	value_errors = 0;
	other_errors = 0;
	build_data();
	build_program();
	load_memory();
	run_reference();

	cycles = 0;
	// First reset edge has been applied from here on
	@(posedge clk);
	@(negedge clk);
	while (cop_reset && (cycles < 20)) begin
		check_flag(mem_enable, 1'b0, "mem_enable in reset");
		@(negedge clk);
		cycles++;
	end
	if (cop_reset) begin
		$display("Timeout: reset was never released");
		other_errors++;
	end
	check_flag(mem_enable, 1'b0, "mem_enable in first cycle after reset");

	cycles = 0;
	while (!mem_enable && (cycles < 10)) begin
		@(negedge clk);
		cycles++;
	end
	if (mem_enable) begin
		check_flag(mem_rw, 1'b1, "first request direction");
		check_addr(mem_addr, reset_pc, "first request");
	end else begin
		$display("Timeout: no memory request within 10 cycles after reset");
		other_errors++;
	end

	cycles = 0;
	while ((exp_read_addr.size() > 0) && (cycles < 5000)) begin
		@(negedge clk);
		cycles++;
	end
	if (exp_read_addr.size() > 0) begin
		$display("Timeout: core stopped with %0d reads of the program still due",
			exp_read_addr.size());
		other_errors++;
	end

	// Idle loop time to catch stray writes
	for (int i = 0; i < 40; i++)
		@(negedge clk);
	if (writes_done != exp_store_total) begin
		$display("Memory saw %0d completed writes where the program has %0d stores",
			writes_done, exp_store_total);
		other_errors++;
	end

	$display("Checks: %0d, value errors: %0d, other errors: %0d",
		checks, value_errors, other_errors);
	if ((value_errors == 0) && (other_errors == 0))
		$display("Verification passed");
	else
		$display("Verification failed");
	$finish;
end

endmodule

`default_nettype wire

// File: mips_lite.f
src/mips_pkg.sv
src/alu.sv
src/regfile.sv
src/fetch_unit.sv
src/mem_port.sv
src/control.sv
src/cpu.sv
test/clock_gen.sv
test/cpu_sva.sv
test/tb_cpu.sv

// File: Makefile
# Verilator build and run of the mips_lite testbench
LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps -j 0 \
		--top-module tb_cpu -f mips_lite.f
	-./obj_dir/Vtb_cpu > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then exit 1; fi
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
